// ==== Bender.yml ====
package:
  name: ldst_unit

sources:
  - include_dirs:
      - .
    files:
      - ldst_pkg.sv
      - ldst_decode.sv
      - ldst_load_align.sv
      - ldst_mem_seq.sv
      - ldst_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ldst_unit.sv

// ==== ldst_decode.sv ====
// Load/store command decoder
// Combinational effective address, byte lanes, store data and load shift,
// plus the new stack pointer value for push, pop and system commands

`timescale 1ns/1ps
`default_nettype none
`include "ldst_defines.svh"

module ldst_decode
	import ldst_pkg::*;
(
	input  ldst_cmd_t    cmd,
	input  ldst_word_t   spr,
	output ldst_access_t acc
);

	localparam ldst_word_t STACK_STEP = ldst_word_t'(`LDST_STACK_STEP);

	// Lane mask by size and offset, misaligned halfword gives no lanes
	function automatic ldst_lanes_t byte_lanes(input ldst_size_t size,
		input ldst_shift_t offset);
		ldst_lanes_t lanes;
		case (size)
			`LDST_SIZE_BYTE: lanes = ldst_lanes_t'(4'b0001 << offset);
			`LDST_SIZE_HALF:
			begin
				case (offset)
					2'd0:    lanes = 4'b0011;
					2'd2:    lanes = 4'b1100;
					default: lanes = 4'b0000;
				endcase
			end
			`LDST_SIZE_WORD: lanes = 4'b1111;
			default:         lanes = 4'b0000;
		endcase
		return lanes;
	endfunction

	// Source copied into every lane of its size
	function automatic ldst_word_t store_data(input ldst_size_t size, input ldst_word_t src);
		case (size)
			`LDST_SIZE_BYTE: return {4{src[7:0]}};
			`LDST_SIZE_HALF: return {2{src[15:0]}};
			default:         return src;
		endcase
	endfunction

	logic        mem_op;	// Command touches memory
	logic        is_disp;
	ldst_size_t  size;
	ldst_word_t  base;	// Address before displacement
	ldst_word_t  src;
	ldst_word_t  addr;
	ldst_shift_t offset;

	always_comb
	begin
		mem_op = 1'b0;
		is_disp = 1'b0;
		size = `LDST_SIZE_WORD;
		base = cmd.source1;
		src = cmd.source0;
		acc.rw = 1'b0;
		acc.spr_write = 1'b0;
		acc.spr_next = spr;
		acc.data = '0;
		if (!cmd.sys_mode)
		begin
			acc.rw = cmd.cmd inside {ST8, ST16, ST32, STD8, STD16, STD32, PUSH, PPUSH};
			is_disp = cmd.cmd inside {LDD8, LDD16, LDD32, STD8, STD16, STD32};
			case (cmd.cmd)
				LD8, ST8, LDD8, STD8:
				begin
					mem_op = 1'b1;
					size = `LDST_SIZE_BYTE;
				end
				LD16, ST16, LDD16, STD16:
				begin
					mem_op = 1'b1;
					size = `LDST_SIZE_HALF;
				end
				LD32, ST32, LDD32, STD32:
					mem_op = 1'b1;
				PUSH, PPUSH:
				begin
					mem_op = 1'b1;
					base = spr - STACK_STEP;	// Pre-decrement
					acc.spr_write = 1'b1;
					acc.spr_next = spr - STACK_STEP;
					if (cmd.cmd == PPUSH)
						src = cmd.pc;
				end
				POP:
				begin
					mem_op = 1'b1;
					base = spr;
					acc.spr_write = 1'b1;
					acc.spr_next = spr + STACK_STEP;	// Post-increment
				end
				default:
					mem_op = 1'b0;
			endcase
		end
		else
		begin
			case (cmd.cmd)
				READ_SPR:
				begin
					acc.spr_write = 1'b1;
					acc.data = spr;
				end
				WRITE_SPR:
				begin
					acc.spr_write = 1'b1;
					acc.spr_next = cmd.source0;
				end
				ADD_SPR:
				begin
					acc.spr_write = 1'b1;
					acc.spr_next = cmd.source0 + cmd.source1;
				end
				default:
					acc.spr_write = 1'b0;
			endcase
		end

		// Displacement scaled by access size
		addr = base + (is_disp ? cmd.adv_data << size : '0);
		offset = addr[1:0];

		acc.addr = addr;
		acc.size = size;
		acc.lanes = byte_lanes(size, offset);
		case (size)
			`LDST_SIZE_BYTE: acc.shift = offset;
			`LDST_SIZE_HALF: acc.shift = {offset[1], 1'b0};
			default:         acc.shift = 2'd0;
		endcase
		acc.wdata = store_data(size, src);
		acc.fault = mem_op && size == `LDST_SIZE_HALF && offset[0];
		acc.access = mem_op && !acc.fault;
	end

endmodule

`default_nettype wire

// ==== ldst_defines.svh ====
// Load/store unit parameters
// Data width, stack step, SPR reset value and the access size codes

`ifndef LDST_DEFINES_SVH
`define LDST_DEFINES_SVH

// Data and address width
`define LDST_XLEN 32

// Byte lanes per word
`define LDST_LANES (`LDST_XLEN / 8)

// Bytes moved per push or pop
`define LDST_STACK_STEP 4

// Stack pointer after reset
`define LDST_SPR_RESET 32'h0000_1000

// Access size codes
`define LDST_SIZE_BYTE 2'd0
`define LDST_SIZE_HALF 2'd1
`define LDST_SIZE_WORD 2'd2

`endif

// ==== ldst_load_align.sv ====
// Load data aligner
// Moves the addressed bytes down to bit 0 and zero-extends by access size

`timescale 1ns/1ps
`default_nettype none
`include "ldst_defines.svh"

module ldst_load_align
	import ldst_pkg::*;
(
	input  ldst_word_t  rdata,
	input  ldst_size_t  size,
	input  ldst_shift_t shift,
	output ldst_word_t  data
);

	ldst_word_t shifted;

	assign shifted = rdata >> {shift, 3'b000};	// Offset in bytes

	always_comb
	begin
		case (size)
			`LDST_SIZE_BYTE: data = ldst_word_t'(shifted[7:0]);
			`LDST_SIZE_HALF: data = ldst_word_t'(shifted[15:0]);
			default:         data = shifted;
		endcase
	end

endmodule

`default_nettype wire

// ==== ldst_mem_seq.sv ====
// Load/store sequencer
// Runs one four-phase transaction on the data memory port, then
// acknowledges the command and waits for its request to drop

`timescale 1ns/1ps
`default_nettype none

module ldst_mem_seq
	import ldst_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	input  logic       start,
	input  logic       access,
	input  logic       rw,
	output logic       mem_req,
	input  logic       mem_ack,
	input  ldst_word_t mem_rdata,
	output ldst_word_t rdata,
	output logic       cmd_ack,
	input  logic       cmd_req,
	output logic       busy,
	output logic       done
);

	ldst_state_e state;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			mem_req <= 1'b0;
			cmd_ack <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (start)
						state <= MEM_REQ;
				MEM_REQ:
				begin
					if (!access)
						state <= DONE;	// No transaction, straight to ack
					else if (mem_req && mem_ack)
					begin
						mem_req <= 1'b0;
						state <= MEM_REL;
					end
					else
						mem_req <= 1'b1;
				end
				MEM_REL:
					if (!mem_ack)
						state <= DONE;
				DONE:
				begin
					cmd_ack <= 1'b1;
					state <= RELEASE;
				end
				RELEASE:
				begin
					if (!cmd_req)
					begin
						cmd_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Read data held for the aligner until the next load
	always_ff @(posedge clock)
	begin
		if (state == MEM_REQ && mem_req && mem_ack && !rw)
			rdata <= mem_rdata;
	end

	assign busy = state != IDLE;
	assign done = state == DONE;

	a_req_held: assert property (@(posedge clock) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	a_req_ack_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(mem_req && cmd_ack))
		else $error("mem_req and cmd_ack high together");

endmodule

`default_nettype wire

// ==== ldst_pkg.sv ====
// Load/store unit types
// Word, lane and command types, the sequencer states and the port structs

`default_nettype none

package ldst_pkg;

	`include "ldst_defines.svh"

	typedef logic [`LDST_XLEN-1:0]  ldst_word_t;
	typedef logic [`LDST_LANES-1:0] ldst_lanes_t;
	typedef logic [1:0]             ldst_shift_t;	// Byte offset in word
	typedef logic [1:0]             ldst_size_t;	// 0 byte, 1 half, 2 word

	// Normal commands in the low codes, system commands above
	typedef enum logic [4:0] {
		LD8       = 5'h00,
		LD16      = 5'h01,
		LD32      = 5'h02,
		ST8       = 5'h03,
		ST16      = 5'h04,
		ST32      = 5'h05,
		PUSH      = 5'h06,
		PPUSH     = 5'h07,
		POP       = 5'h08,
		LDD8      = 5'h09,
		LDD16     = 5'h0a,
		LDD32     = 5'h0b,
		STD8      = 5'h0c,
		STD16     = 5'h0d,
		STD32     = 5'h0e,
		READ_SPR  = 5'h10,
		WRITE_SPR = 5'h11,
		ADD_SPR   = 5'h12
	} ldst_cmd_e;

	typedef enum logic [2:0] {
		IDLE,
		MEM_REQ,
		MEM_REL,
		DONE,
		RELEASE
	} ldst_state_e;

	typedef struct packed {
		ldst_cmd_e  cmd;
		logic       sys_mode;	// 1 selects the system commands
		ldst_word_t source0;
		ldst_word_t source1;
		ldst_word_t adv_data;	// Displacement
		ldst_word_t pc;
	} ldst_cmd_t;

	typedef struct packed {
		logic        access;	// Memory transaction needed
		logic        rw;	// 1 write
		ldst_word_t  addr;
		ldst_word_t  wdata;
		ldst_size_t  size;
		ldst_lanes_t lanes;
		ldst_shift_t shift;
		logic        spr_write;
		ldst_word_t  spr_next;
		ldst_word_t  data;	// Result data for non-load commands
		logic        fault;
	} ldst_access_t;

	typedef struct packed {
		logic        rw;
		ldst_word_t  addr;	// Word aligned
		ldst_word_t  wdata;
		ldst_lanes_t lanes;
	} ldst_mem_t;

	typedef struct packed {
		ldst_word_t data;
		logic       spr_valid;
		ldst_word_t spr;
		logic       fault;
	} ldst_result_t;

endpackage

`default_nettype wire

// ==== ldst_stim.txt ====
// cmd sys source0 source1 adv_data pc exp_data exp_spr exp_spr_valid exp_fault
// Memory starts all zero, the SPR starts at 00001000
05 0 11223344 00000010 00000000 00000000 00000000 00001000 0 0 // Word store
02 0 00000000 00000010 00000000 00000000 11223344 00001000 0 0
00 0 00000000 00000010 00000000 00000000 00000044 00001000 0 0
00 0 00000000 00000011 00000000 00000000 00000033 00001000 0 0
00 0 00000000 00000013 00000000 00000000 00000011 00001000 0 0
01 0 00000000 00000010 00000000 00000000 00003344 00001000 0 0
01 0 00000000 00000012 00000000 00000000 00001122 00001000 0 0
03 0 000000ab 00000015 00000000 00000000 00000000 00001000 0 0 // Byte into lane 1
02 0 00000000 00000014 00000000 00000000 0000ab00 00001000 0 0
04 0 0000beef 00000016 00000000 00000000 00000000 00001000 0 0
01 0 00000000 00000016 00000000 00000000 0000beef 00001000 0 0
00 0 00000000 00000015 00000000 00000000 000000ab 00001000 0 0
00 0 00000000 00000017 00000000 00000000 000000be 00001000 0 0
0e 0 cafef00d 00000020 00000003 00000000 00000000 00001000 0 0 // Displacement forms
02 0 00000000 0000002c 00000000 00000000 cafef00d 00001000 0 0
0d 0 00001234 00000030 00000001 00000000 00000000 00001000 0 0
02 0 00000000 00000030 00000000 00000000 12340000 00001000 0 0
0c 0 00000077 00000038 00000003 00000000 00000000 00001000 0 0
09 0 00000000 00000038 00000003 00000000 00000077 00001000 0 0
0a 0 00000000 0000002c 00000001 00000000 0000cafe 00001000 0 0
0b 0 00000000 00000024 00000002 00000000 cafef00d 00001000 0 0
06 0 deadbeef 00000000 00000000 00000000 00000000 00000ffc 1 0 // Stack
07 0 11111111 00000000 00000000 00000400 00000000 00000ff8 1 0
08 0 00000000 00000000 00000000 00000000 00000400 00000ffc 1 0
08 0 00000000 00000000 00000000 00000000 deadbeef 00001000 1 0
10 1 00000000 00000000 00000000 00000000 00001000 00001000 1 0 // System commands
11 1 00000080 00000000 00000000 00000000 00000000 00000080 1 0
12 1 00000080 00000040 00000000 00000000 00000000 000000c0 1 0
10 1 00000000 00000000 00000000 00000000 000000c0 000000c0 1 0
01 0 00000000 00000011 00000000 00000000 00000000 000000c0 0 1 // Misaligned halfwords
04 0 0000ffff 00000013 00000000 00000000 00000000 000000c0 0 1
0d 0 00005555 00000031 00000002 00000000 00000000 000000c0 0 1
06 0 0badc0de 00000000 00000000 00000000 00000000 000000bc 1 0
02 0 00000000 000000bc 00000000 00000000 0badc0de 000000bc 0 0
08 0 00000000 00000000 00000000 00000000 0badc0de 000000c0 1 0

// ==== ldst_unit.sv ====
// Load/store execute stage
// Captures one command, holds the stack pointer and ties the decoder,
// memory sequencer and load aligner together

`timescale 1ns/1ps
`default_nettype none
`include "ldst_defines.svh"

module ldst_unit
	import ldst_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  logic         cmd_req,
	output logic         cmd_ack,
	input  ldst_cmd_t    cmd,
	output ldst_result_t result,
	output logic         mem_req,
	input  logic         mem_ack,
	output ldst_mem_t    mem,
	input  ldst_word_t   mem_rdata
);

	ldst_cmd_t    cmd_q;
	ldst_word_t   spr_q;
	ldst_access_t acc;
	ldst_word_t   ld_raw;	// Latched memory word
	ldst_word_t   ld_data;
	logic         start;
	logic         busy;
	logic         done;

	assign start = cmd_req && !busy;

	always_ff @(posedge clock)
	begin
		if (start)
			cmd_q <= cmd;
	end

	// SPR updates on the edge that raises cmd_ack
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			spr_q <= `LDST_SPR_RESET;
		else if (done && acc.spr_write)
			spr_q <= acc.spr_next;
	end

	ldst_decode u_decode (
		.cmd (cmd_q),
		.spr (spr_q),
		.acc (acc)
	);

	ldst_mem_seq u_seq (
		.clock     (clock),
		.rst_n     (rst_n),
		.start     (start),
		.access    (acc.access),
		.rw        (acc.rw),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.rdata     (ld_raw),
		.cmd_ack   (cmd_ack),
		.cmd_req   (cmd_req),
		.busy      (busy),
		.done      (done)
	);

	ldst_load_align u_align (
		.rdata (ld_raw),
		.size  (acc.size),
		.shift (acc.shift),
		.data  (ld_data)
	);

	assign mem.rw = acc.rw;
	assign mem.addr = {acc.addr[`LDST_XLEN-1:2], 2'b00};
	assign mem.wdata = acc.wdata;
	assign mem.lanes = acc.lanes;

	// spr_q already holds the new value while cmd_ack is high
	assign result.data = (acc.access && !acc.rw) ? ld_data : acc.data;
	assign result.spr_valid = acc.spr_write;
	assign result.spr = spr_q;
	assign result.fault = acc.fault;

	// Port command must match the captured one while its request is up
	a_cmd_stable: assert property (@(posedge clock) disable iff (!rst_n)
		busy && cmd_req |-> cmd == cmd_q)
		else $error("command changed while its request was pending");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
ldst_pkg.sv
ldst_decode.sv
ldst_load_align.sv
ldst_mem_seq.sv
ldst_unit.sv
tb_ldst_unit.sv

// ==== tb_ldst_unit.sv ====
// Testbench for the load/store execute stage
// Reads command vectors and expected results from ldst_stim.txt, models a
// 64-word data memory with a random ack delay and checks every command

`timescale 1ns/1ps
`default_nettype none
`include "ldst_defines.svh"

module tb_ldst_unit
	import ldst_pkg::*;
();

	localparam int VEC_WORDS = 10;	// Tokens per vector line
	localparam int MAX_VECS = 64;
	localparam int CYCLES_PER_VEC = 20;
	localparam int RESET_CYCLES = 5;
	localparam int CLOCK_PERIOD = 100;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] NO_VECTOR = 32'hffff_ffff;	// Marks unused stimulus words

	logic         clock;
	logic         rst_n;
	logic         cmd_req;
	logic         cmd_ack;
	ldst_cmd_t    cmd;
	ldst_result_t result;
	logic         mem_req;
	logic         mem_ack;
	ldst_mem_t    mem;
	ldst_word_t   mem_rdata;

	logic [31:0] stim_mem [0:VEC_WORDS*MAX_VECS-1];
	ldst_word_t  mem_model [0:63];
	logic [31:0] lfsr;
	int          num_vecs;
	int          mem_count;	// Memory transactions of the current command
	logic        loaded;

	ldst_unit uut (
		.clock     (clock),
		.rst_n     (rst_n),
		.cmd_req   (cmd_req),
		.cmd_ack   (cmd_ack),
		.cmd       (cmd),
		.result    (result),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem       (mem),
		.mem_rdata (mem_rdata)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string test_name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
			fail_run($sformatf("CHECK FAILED %s %s expected %08h actual %08h",
				test_name, field, expected, actual));
	endtask

	// Galois step, bit 0 is the bit shifted out
	function automatic logic [31:0] next_lfsr(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		return state >> 1;
	endfunction

	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = next_lfsr(lfsr);
		end
	endtask

	// Data memory, answers each request after 0 to 3 cycles
	always
	begin : memory_model
		int delay;
		int idx;
		@(negedge clock);
		if (rst_n && mem_req && !mem_ack)
		begin
			take_bits(2, delay);
			repeat (delay)
				@(negedge clock);
			assert (mem_req)
			else
				fail_run("mem_req dropped before the memory acknowledged it");
			idx = int'(mem.addr[7:2]);
			if (mem.rw)
			begin
				for (int k = 0; k < 4; k++)
					if (mem.lanes[k])
						mem_model[idx][8*k +: 8] = mem.wdata[8*k +: 8];
			end
			else
				mem_rdata = mem_model[idx];
			mem_ack = 1'b1;
			mem_count++;
			do
				@(negedge clock);
			while (mem_req);
			mem_ack = 1'b0;
		end
	end

	always @(negedge clock)
	begin
		if (rst_n)
		begin
			assert (!(mem_req && cmd_ack))
			else
				fail_run("mem_req and cmd_ack were high at the same time");
		end
	end

	initial
	begin : watchdog
		longint limit;
		wait (loaded);
		limit = (longint'(num_vecs) * CYCLES_PER_VEC + RESET_CYCLES + 10) * CLOCK_PERIOD;
		#(limit);
		fail_run($sformatf("Watchdog timeout after %0d ns, a handshake never finished", limit));
	end

	// One command through the four-phase handshake, then its checks
	task automatic run_vector(input int v);
		ldst_cmd_e code;
		string     name;
		int        base;
		logic      exp_fault;
		logic      exp_sys;
		base = v * VEC_WORDS;
		code = ldst_cmd_e'(stim_mem[base][4:0]);
		name = $sformatf("vec%0d_%s", v, code.name());
		exp_sys = stim_mem[base+1][0];
		exp_fault = stim_mem[base+9][0];

		// Memory port idle between commands
		check_value(name, "mem_req before cmd_req", 32'd0, mem_req);
		cmd.cmd = code;
		cmd.sys_mode = exp_sys;
		cmd.source0 = stim_mem[base+2];
		cmd.source1 = stim_mem[base+3];
		cmd.adv_data = stim_mem[base+4];
		cmd.pc = stim_mem[base+5];
		mem_count = 0;
		cmd_req = 1'b1;

		do
			@(negedge clock);
		while (!cmd_ack);

		check_value(name, "data", stim_mem[base+6], result.data);
		check_value(name, "spr", stim_mem[base+7], result.spr);
		check_value(name, "spr_valid", stim_mem[base+8], 32'(result.spr_valid));
		check_value(name, "fault", 32'(exp_fault), 32'(result.fault));
		// System commands and faults must leave the memory port alone
		check_value(name, "memory transactions", (exp_sys || exp_fault) ? 32'd0 : 32'd1,
			mem_count);

		cmd_req = 1'b0;
		do
			@(negedge clock);
		while (cmd_ack);
	endtask

	initial
	begin : main
		clock = 1'b0;
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		mem_count = 0;
		loaded = 1'b0;
		num_vecs = 0;
		lfsr = 32'd87165;
		for (int i = 0; i < 64; i++)
			mem_model[i] = '0;
		for (int i = 0; i < VEC_WORDS*MAX_VECS; i++)
			stim_mem[i] = NO_VECTOR;

		$readmemh("ldst_stim.txt", stim_mem);
		while (num_vecs < MAX_VECS && stim_mem[num_vecs*VEC_WORDS] != NO_VECTOR)
			num_vecs++;
		if (num_vecs == 0)
			fail_run("No command vectors were read from ldst_stim.txt");
		loaded = 1'b1;

		repeat (RESET_CYCLES)
			@(negedge clock);
		rst_n = 1'b1;
		check_value("reset", "cmd_ack", 32'd0, cmd_ack);
		check_value("reset", "mem_req", 32'd0, mem_req);
		check_value("reset", "spr", `LDST_SPR_RESET, result.spr);

		for (int v = 0; v < num_vecs; v++)
			run_vector(v);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
